//--- Makefile
TOP := lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/lsu_assert.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_assert (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic credit_return,
    input logic resp_valid
);
    import lsu_pkg::*;

    logic [3:0] occupancy;  // Pushes minus pops, tracks the queue count

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + {3'd0, req_valid} - {3'd0, credit_return};
        end
    end

    queue_bound: assert property (@(posedge clk) disable iff (rst)
        occupancy <= 4'(QUEUE_DEPTH))
        else $error("Request queue holds more than %0d entries", QUEUE_DEPTH);

    resp_single: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid)
        else $error("resp_valid stayed high for two cycles");

    credit_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !credit_return)
        else $error("credit_return high in the first cycle after reset");

endmodule

bind lsu_top lsu_assert assert_i (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .credit_return (credit_return),
    .resp_valid    (resp_valid)
);

`default_nettype wire

//--- dv/lsu_stim.txt
# test op rt funct addr wdata reg_old expected, all hex; expected is used only for loads
# tests 1 round trip, 2 partial stores, 3 LWL/LWR, 4 no memory access, 5 credit burst
1 2b 08 00 00000010 8091a2f3 00000000 00000000
1 23 09 00 00000010 00000000 00000000 8091a2f3
1 0f 0a 00 00000010 00000000 00000000 8091a2f3
1 21 0b 00 00000012 00000000 00000000 ffff8091
1 25 0c 00 00000010 00000000 00000000 0000a2f3
1 20 0d 00 00000011 00000000 00000000 ffffffa2
1 24 0e 00 00000013 00000000 00000000 00000080
2 2b 08 00 00000020 11223344 00000000 00000000
2 28 08 00 00000021 000000aa 00000000 00000000
2 29 08 00 00000022 0000bbcc 00000000 00000000
2 23 11 00 00000020 00000000 00000000 bbccaa44
3 22 12 00 00000011 00000000 55667788 8091a288
3 22 13 00 00000013 00000000 55667788 80667788
3 26 14 00 00000010 00000000 55667788 556677f3
3 26 15 00 00000012 00000000 55667788 5591a2f3
4 03 1f 00 00000020 ffffffff 00000000 00000000
4 00 1f 09 00000020 ffffffff 00000000 00000000
4 01 10 00 00000020 ffffffff 00000000 00000000
4 00 03 20 00000020 ffffffff 00000000 00000000
4 29 08 00 00000021 0000eeee 00000000 00000000
4 21 16 00 00000023 00000000 00000000 00000000
4 23 17 00 00000020 00000000 00000000 bbccaa44
5 2b 08 00 00000030 cafef00d 00000000 00000000
5 23 18 00 00000030 00000000 00000000 cafef00d
5 28 08 00 00000031 0000005a 00000000 00000000
5 24 19 00 00000031 00000000 00000000 0000005a
5 25 1a 00 00000032 00000000 00000000 0000cafe
5 23 1b 00 00000030 00000000 00000000 cafe5a0d

//--- dv/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;
    import mips_isa_pkg::*;
    import lsu_pkg::*;

    localparam int CYCLES_PER_VEC = 20;
    localparam int NUM_TESTS      = 5;

    logic      clk;
    logic      rst;
    logic      req_valid;
    mem_req_t  req;
    logic      credit_return;
    logic      resp_valid;
    mem_resp_t resp;

    mem_req_t  vec_req[$];
    int        vec_test[$];
    word_t     vec_exp[$];
    mem_resp_t exp_q[$];  // Responses still owed, in request order
    int        credits;
    int        pulses;
    int        errors;
    int        n_vec;
    int        n_run;
    int        n_pass;
    bit        loaded;

    lsu_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .resp_valid    (resp_valid),
        .resp          (resp)
    );

    always #10 clk = ~clk;

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One clock, counting returned credits
    task automatic tick();
        @(posedge clk);
        if (credit_return) begin
            credits++;
            pulses++;
        end
    endtask

    function automatic bit expects_response(input mem_req_t r);
        case (r.op)
            OP_LB, OP_LBU, OP_LW, OP_LWL, OP_LWR, OP_LUI: return 1'b1;
            OP_LH, OP_LHU: return !r.addr[0];  // Misaligned half has no enables
            default: return 1'b0;
        endcase
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "word and halfword round trip";
            2: return "partial stores";
            3: return "LWL and LWR merge";
            4: return "requests without memory access";
            5: return "credit burst";
            default: return "unnamed";
        endcase
    endfunction

    task automatic load_stim();
        int          fd;
        int          n;
        int          t;
        string       line;
        mem_req_t    r;
        logic [31:0] f_op;
        logic [31:0] f_rt;
        logic [31:0] f_funct;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_old;
        logic [31:0] f_exp;
        fd = $fopen("dv/lsu_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/lsu_stim.txt, no stimulus was run");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h", t, f_op, f_rt, f_funct,
                                f_addr, f_wdata, f_old, f_exp);
                    if (n == 8) begin
                        r.op      = f_op[5:0];
                        r.rt      = f_rt[4:0];
                        r.funct   = f_funct[5:0];
                        r.addr    = f_addr;
                        r.wdata   = f_wdata;
                        r.reg_old = f_old;
                        vec_req.push_back(r);
                        vec_test.push_back(t);
                        vec_exp.push_back(f_exp);
                    end else begin
                        $display("Stim line could not be parsed: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int test_id);
        int start_errors;
        int n_req;
        int idle;
        start_errors = errors;
        n_req = 0;
        pulses = 0;
        foreach (vec_req[i]) begin
            if (vec_test[i] == test_id) begin
                idle = (test_id == 5) ? 0 : int'($urandom % 3);  // Burst test runs back to back
                repeat (idle) begin
                    req_valid <= 1'b0;
                    tick();
                end
                while (credits == 0) begin
                    req_valid <= 1'b0;
                    tick();
                end
                req_valid <= 1'b1;
                req       <= vec_req[i];
                credits--;
                n_req++;
                if (expects_response(vec_req[i])) begin
                    exp_q.push_back(mem_resp_t'({vec_req[i].rt, vec_exp[i]}));
                end
                tick();
            end
        end
        req_valid <= 1'b0;
        while (credits != QUEUE_DEPTH || exp_q.size() != 0) begin
            tick();
        end
        repeat (3) begin
            tick();  // Catch stray responses
        end
        compare("credit_return pulses", 64'(pulses), 64'(n_req));
        n_run++;
        if (errors == start_errors) begin
            n_pass++;
        end
        $display("Test %0d %s: %s, %0d requests, %0d errors", test_id, test_name(test_id),
                 (errors == start_errors) ? "passed" : "failed", n_req, errors - start_errors);
    endtask

    always @(posedge clk) begin
        if (!rst && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected response at %0t while no load was outstanding", $time);
                errors++;
            end else begin
                compare("load response rd and data", 64'(resp), 64'(exp_q.pop_front()));
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_vec * CYCLES_PER_VEC + 20) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", n_vec * CYCLES_PER_VEC + 20);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(92318));
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        credits   = QUEUE_DEPTH;
        pulses    = 0;
        errors    = 0;
        n_run     = 0;
        n_pass    = 0;
        load_stim();
        n_vec  = vec_req.size();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 n_run, n_pass, n_run - n_pass, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
source/mips_isa_pkg.sv
source/lsu_pkg.sv
source/mem_int.sv
source/req_queue.sv
source/data_ram.sv
source/load_merge.sv
source/lsu_ctrl.sv
source/lsu_top.sv
dv/lsu_assert.sv
dv/lsu_tb.sv

//--- source/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           we,
    input  logic [lsu_pkg::RAM_ADDR_W-1:0] addr,
    input  lsu_pkg::byte_en_t              be,
    input  lsu_pkg::word_t                 wdata,
    output lsu_pkg::word_t                 rdata
);
    import lsu_pkg::*;

    word_t mem [RAM_WORDS] = '{default: '0};  // Starts cleared

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
            rdata <= mem[addr];  // Old word on a write
        end
    end

endmodule

`default_nettype wire

//--- source/load_merge.sv
`timescale 1ns/10ps
`default_nettype none

module load_merge (
    input  mips_isa_pkg::opcode_t op,
    input  lsu_pkg::byte_idx_t    byte_idx,
    input  lsu_pkg::word_t        rdata,
    input  lsu_pkg::word_t        reg_old,
    output lsu_pkg::word_t        result
);
    import mips_isa_pkg::*;
    import lsu_pkg::*;

    word_t       shifted;
    logic [15:0] half;
    byte_en_t    merge_mask;

    assign shifted = rdata >> {byte_idx, 3'b000};        // Selected byte in [7:0]
    assign half    = byte_idx[1] ? rdata[31:16] : rdata[15:0];

    // Same lane pattern that mem_int enables for LWL and LWR
    assign merge_mask = (op == OP_LWL) ? (4'b1111 << byte_idx)
                                       : (4'b1111 >> (2'd3 - byte_idx));

    always_comb begin
        result = rdata;  // LW and LUI
        case (op)
            OP_LB: begin
                result = {{24{shifted[7]}}, shifted[7:0]};
            end
            OP_LBU: begin
                result = {24'd0, shifted[7:0]};
            end
            OP_LH: begin
                result = {{16{half[15]}}, half};
            end
            OP_LHU: begin
                result = {16'd0, half};
            end
            OP_LWL, OP_LWR: begin
                for (int i = 0; i < 4; i++) begin
                    result[8*i +: 8] = merge_mask[i] ? rdata[8*i +: 8] : reg_old[8*i +: 8];
                end
            end
            default: begin
                result = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/lsu_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            not_empty,
    input  lsu_pkg::mem_req_t               head,
    input  mips_isa_pkg::access_kind_e      kind,
    input  lsu_pkg::word_t                  word_addr,
    input  lsu_pkg::byte_idx_t              byte_idx,
    input  lsu_pkg::byte_en_t               byte_en,
    input  lsu_pkg::word_t                  result,
    output logic                            pop,
    output logic                            ram_en,
    output logic                            ram_we,
    output logic [lsu_pkg::RAM_ADDR_W-1:0]  ram_addr,
    output lsu_pkg::byte_en_t               ram_be,
    output lsu_pkg::word_t                  ram_wdata,
    output lsu_pkg::mem_req_t               cur_req,
    output lsu_pkg::byte_idx_t              cur_idx,
    output logic                            resp_valid,
    output lsu_pkg::mem_resp_t              resp
);
    import mips_isa_pkg::*;
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } state_t;

    state_t       state;
    access_kind_e cur_kind;
    word_t        cur_addr;
    byte_en_t     cur_be;
    logic         is_mem;

    // Misaligned halves have no enables and never touch the RAM
    assign is_mem = (cur_kind == ACC_LOAD || cur_kind == ACC_STORE) && (cur_be != '0);

    assign pop = (state == IDLE) && not_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    state <= (is_mem && cur_kind == ACC_LOAD) ? RESP : IDLE;
                end
                RESP: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin  // Latch head and its decode
            cur_req  <= head;
            cur_kind <= kind;
            cur_addr <= word_addr;
            cur_idx  <= byte_idx;
            cur_be   <= byte_en;
        end
    end

    assign ram_en    = (state == ACCESS) && is_mem;
    assign ram_we    = (state == ACCESS) && is_mem && (cur_kind == ACC_STORE);
    assign ram_addr  = cur_addr[RAM_ADDR_W+1:2];
    assign ram_be    = cur_be;
    assign ram_wdata = cur_req.wdata << {cur_idx, 3'b000};  // Move data to its lanes

    assign resp_valid = (state == RESP);
    assign resp.rd    = cur_req.rt;
    assign resp.data  = result;

endmodule

`default_nettype wire

//--- source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int QUEUE_DEPTH = 4;                     // Also the CPU credit count
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int RAM_WORDS   = 256;
    localparam int RAM_ADDR_W  = $clog2(RAM_WORDS);     // Word index, addr[9:2]

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;   // Bit i enables byte lane i
    typedef logic [1:0]  byte_idx_t;

    typedef struct packed {
        mips_isa_pkg::opcode_t  op;
        mips_isa_pkg::reg_idx_t rt;
        mips_isa_pkg::funct_t   funct;
        word_t                  addr;     // Effective address
        word_t                  wdata;    // Store data, unaligned
        word_t                  reg_old;  // Old rt value for LWL/LWR
    } mem_req_t;

    typedef struct packed {
        mips_isa_pkg::reg_idx_t rd;
        word_t                  data;
    } mem_resp_t;

endpackage

`default_nettype wire

//--- source/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  lsu_pkg::mem_req_t  req,
    output logic               credit_return,
    output logic               resp_valid,
    output lsu_pkg::mem_resp_t resp
);
    import mips_isa_pkg::*;
    import lsu_pkg::*;

    mem_req_t                head;
    mem_req_t                cur_req;
    logic                    not_empty;
    logic                    pop;
    access_kind_e            kind;
    word_t                   word_addr;
    byte_idx_t               byte_idx;
    byte_idx_t               cur_idx;
    byte_en_t                byte_en;
    logic                    ram_en;
    logic                    ram_we;
    logic [RAM_ADDR_W-1:0]   ram_addr;
    byte_en_t                ram_be;
    word_t                   ram_wdata;
    word_t                   rdata;
    word_t                   result;

    req_queue queue_i (
        .clk           (clk),
        .rst           (rst),
        .push          (req_valid),
        .din           (req),
        .pop           (pop),
        .head          (head),
        .not_empty     (not_empty),
        .credit_return (credit_return)
    );

    mem_int decode_i (  // Decodes the queue head
        .op         (head.op),
        .rt         (head.rt),
        .func       (head.funct),
        .cpu_out    (head.addr),
        .mem_addr   (word_addr),
        .byte_idx   (byte_idx),
        .byteenable (byte_en),
        .kind       (kind)
    );

    lsu_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .not_empty  (not_empty),
        .head       (head),
        .kind       (kind),
        .word_addr  (word_addr),
        .byte_idx   (byte_idx),
        .byte_en    (byte_en),
        .result     (result),
        .pop        (pop),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata),
        .cur_req    (cur_req),
        .cur_idx    (cur_idx),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    data_ram ram_i (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (rdata)
    );

    load_merge merge_i (
        .op       (cur_req.op),
        .byte_idx (cur_idx),
        .rdata    (rdata),
        .reg_old  (cur_req.reg_old),
        .result   (result)
    );

endmodule

`default_nettype wire

//--- source/mem_int.sv
`timescale 1ns/10ps
`default_nettype none

module mem_int (
    input  mips_isa_pkg::opcode_t      op,
    input  mips_isa_pkg::reg_idx_t     rt,
    input  mips_isa_pkg::funct_t       func,
    input  lsu_pkg::word_t             cpu_out,
    output lsu_pkg::word_t             mem_addr,
    output lsu_pkg::byte_idx_t         byte_idx,
    output lsu_pkg::byte_en_t          byteenable,
    output mips_isa_pkg::access_kind_e kind
);
    import mips_isa_pkg::*;

    assign byte_idx = cpu_out[1:0];
    assign mem_addr = {cpu_out[31:2], 2'b00};  // Word aligned

    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_LH, OP_LHU,
            OP_LUI, OP_LW, OP_LWL, OP_LWR: begin
                kind = ACC_LOAD;
            end
            OP_SB, OP_SH, OP_SW: begin
                kind = ACC_STORE;
            end
            OP_REGIMM: begin
                // BLTZAL and BGEZAL write the link register
                if (rt == RT_BLTZAL || rt == RT_BGEZAL) begin
                    kind = ACC_LINK;
                end else begin
                    kind = ACC_OTHER;
                end
            end
            OP_SPECIAL: begin
                kind = (func == FUNCT_JALR) ? ACC_LINK : ACC_OTHER;
            end
            OP_JAL: begin
                kind = ACC_LINK;
            end
            default: begin
                kind = ACC_OTHER;
            end
        endcase
    end

    always_comb begin
        if (kind == ACC_LOAD || kind == ACC_STORE) begin
            case (op)
                OP_LB, OP_LBU, OP_SB: begin
                    byteenable = 4'b0001 << byte_idx;
                end
                OP_LH, OP_LHU, OP_SH: begin
                    case (byte_idx)
                        2'd0:    byteenable = 4'b0011;
                        2'd2:    byteenable = 4'b1100;
                        default: byteenable = 4'b0000;  // Misaligned half
                    endcase
                end
                OP_LWL: begin
                    byteenable = 4'b1111 << byte_idx;          // Upper lanes from idx
                end
                OP_LWR: begin
                    byteenable = 4'b1111 >> (2'd3 - byte_idx); // Lower lanes up to idx
                end
                default: begin
                    byteenable = 4'b1111;  // LW, LUI, SW
                end
            endcase
        end else begin
            byteenable = 4'b1111;
        end
    end

endmodule

`default_nettype wire

//--- source/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [5:0] opcode_t;   // Primary opcode, instr[31:26]
    typedef logic [5:0] funct_t;    // R-type function, instr[5:0]
    typedef logic [4:0] reg_idx_t;  // rt field, also the load destination

    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LWL     = 6'b100010;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_LWR     = 6'b100110;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    localparam funct_t   FUNCT_JALR = 6'b001001;
    localparam reg_idx_t RT_BLTZAL  = 5'b10000;
    localparam reg_idx_t RT_BGEZAL  = 5'b10001;

    typedef enum logic [1:0] {
        ACC_OTHER = 2'd0,
        ACC_STORE = 2'd1,
        ACC_LOAD  = 2'd2,
        ACC_LINK  = 2'd3
    } access_kind_e;

endpackage

`default_nettype wire

//--- source/req_queue.sv
`timescale 1ns/10ps
`default_nettype none

module req_queue (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  lsu_pkg::mem_req_t din,
    input  logic              pop,
    output lsu_pkg::mem_req_t head,
    output logic              not_empty,
    output logic              credit_return
);
    import lsu_pkg::*;

    mem_req_t               fifo_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;
    logic                   do_pop;

    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;
    assign head      = fifo_mem[rd_ptr];

    // Pop comes from controller state only, so no CPU input reaches the credit
    assign credit_return = do_pop;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push with pop
            endcase
        end
    end

endmodule

`default_nettype wire
